// File: source/ex_pkg.sv
////////////////////
// Execute stage shared definitions
// Data widths, word types and operation encodings
////////////////////
package ex_pkg;

  localparam int unsigned XLEN       = 32; // Data path width
  localparam int unsigned REG_ADDR_W = 6;  // Integer plus FP register banks
  localparam int unsigned SHAMT_W    = 5;  // Shift amount field of operand B

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [2*XLEN-1:0]     dword_t;    // Full multiplier product
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////
  // ALU operations
  ////////////////////
  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    ALU_SLT  = 5'h05, // Signed set-less-than
    ALU_SLTU = 5'h06,
    ALU_SLL  = 5'h07,
    ALU_SRL  = 5'h08,
    ALU_SRA  = 5'h09,
    // Branch compares
    ALU_EQ   = 5'h10,
    ALU_NE   = 5'h11,
    ALU_LT   = 5'h12,
    ALU_GE   = 5'h13,
    ALU_LTU  = 5'h14,
    ALU_GEU  = 5'h15
  } alu_op_e;

  ////////////////////
  // Multiplier operations
  ////////////////////
  typedef enum logic [1:0] {
    MULT_MUL   = 2'd0, // Low word, zero latency
    MULT_MULH  = 2'd1, // High word, signed x signed
    MULT_MULHU = 2'd2  // High word, unsigned x unsigned
  } mult_op_e;

endpackage

// File: source/ex_mult_if.sv
////////////////////
// Multiplier link
// Operands from the stage boundary, result and stall to the control
////////////////////
interface ex_mult_if;
  import ex_pkg::*;

  logic     en;         // Multiplier instruction in EX
  mult_op_e op;
  word_t    op_a;
  word_t    op_b;
  word_t    result;
  logic     ready;      // Low while a high product is in flight
  logic     multicycle; // First cycle of MULH/MULHU
  logic     ex_ready;   // Stage accepts the result

  // Multiplier side
  modport unit (input en, op, op_a, op_b, ex_ready, output result, ready, multicycle);

  // Stage control side
  modport ctrl (input en, result, ready, output ex_ready);

  // Operand source at the stage boundary
  modport src (output en, op, op_a, op_b, input multicycle);

endinterface

// File: source/ex_alu.sv
////////////////////
// Integer ALU
// Add/sub, logic, shifts, set-less-than and branch compares
////////////////////
module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  input  logic            enable_i,
  output ex_pkg::word_t   result_o,
  output logic            comparison_result_o
);
  import ex_pkg::*;

  logic [SHAMT_W-1:0] shamt;      // Low bits of B only
  word_t              adder_sum;
  word_t              result;
  logic               is_equal;
  logic               is_less_s;
  logic               is_less_u;
  logic               cmp;

  assign shamt = operand_b_i[SHAMT_W-1:0];

  ////////////////////
  // Comparator
  ////////////////////
  assign is_equal  = (operand_a_i == operand_b_i);
  assign is_less_s = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_less_u = (operand_a_i < operand_b_i);

  // Shared by branches and set-less-than
  always_comb begin
    case (operator_i)
      ALU_EQ:            cmp = is_equal;
      ALU_NE:            cmp = ~is_equal;
      ALU_LT, ALU_SLT:   cmp = is_less_s;
      ALU_GE:            cmp = ~is_less_s;
      ALU_LTU, ALU_SLTU: cmp = is_less_u;
      ALU_GEU:           cmp = ~is_less_u;
      default:           cmp = 1'b0; // Not a compare
    endcase
  end

  ////////////////////
  // Arithmetic
  ////////////////////
  always_comb begin
    if (operator_i == ALU_SUB) begin
      adder_sum = operand_a_i - operand_b_i;
    end else begin
      adder_sum = operand_a_i + operand_b_i;
    end
  end

  // Result select
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result = adder_sum;
      ALU_AND:          result = operand_a_i & operand_b_i;
      ALU_OR:           result = operand_a_i | operand_b_i;
      ALU_XOR:          result = operand_a_i ^ operand_b_i;
      ALU_SLL:          result = operand_a_i << shamt;
      ALU_SRL:          result = operand_a_i >> shamt;
      ALU_SRA:          result = word_t'($signed(operand_a_i) >>> shamt);
      // SLT/SLTU and branch compares give 0 or 1
      default:          result = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////
  // Zero when idle so EX never forwards stale values
  assign result_o            = enable_i ? result : '0;
  assign comparison_result_o = enable_i & cmp;

endmodule

// File: source/ex_mult.sv
////////////////////
// Integer multiplier
// MUL in one cycle, MULH/MULHU over two cycles
////////////////////
module ex_mult (
  input logic     clk,
  input logic     rst_n,
  ex_mult_if.unit mult
);
  import ex_pkg::*;

  // CALC only exists combinationally, the register holds IDLE or DONE
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } mult_state_e;

  mult_state_e              state_q;   // Registered state
  mult_state_e              state;     // State seen this cycle
  mult_state_e              state_d;
  logic                     is_high;   // MULH or MULHU
  logic                     is_signed; // MULH sign-extends both operands
  logic                     start;
  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [2*XLEN+1:0] prod_full;
  dword_t                   prod;
  dword_t                   prod_q;    // Held product for the high word

  assign is_high   = (mult.op == MULT_MULH) || (mult.op == MULT_MULHU);
  assign is_signed = (mult.op == MULT_MULH);
  assign start     = mult.en && is_high;

  ////////////////////
  // Product
  ////////////////////
  assign op_a_ext  = {is_signed & mult.op_a[XLEN-1], mult.op_a};
  assign op_b_ext  = {is_signed & mult.op_b[XLEN-1], mult.op_b};
  assign prod_full = op_a_ext * op_b_ext;
  assign prod      = prod_full[2*XLEN-1:0]; // Low 64 bits are exact

  // Capture at the end of the CALC cycle
  always_ff @(posedge clk) begin
    if (state == CALC) begin
      prod_q <= prod;
    end
  end

  ////////////////////
  // FSM
  ////////////////////
  assign state = (state_q == IDLE && start) ? CALC : state_q;

  always_comb begin
    case (state)
      CALC:    state_d = DONE;
      DONE:    state_d = mult.ex_ready ? IDLE : DONE; // Hold under back-pressure
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs
  assign mult.ready      = (state != CALC);
  assign mult.multicycle = (state == CALC);
  assign mult.result     = (state == DONE) ? prod_q[2*XLEN-1:XLEN] : prod[XLEN-1:0];

  ////////////////////
  // Checks
  ////////////////////
  // Stall only when leaving IDLE, then the register holds DONE with the high word
  assert property (@(posedge clk) disable iff (!rst_n)
    !mult.ready |-> (state_q == IDLE) ##1 (state_q == DONE && mult.ready));

  // No multicycle start without an instruction
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(mult.multicycle) |-> mult.en);

endmodule

// File: source/ex_pipe_ctrl.sv
////////////////////
// Execute stage control
// Forwarding port mux, EX/WB register and ready/valid
////////////////////
module ex_pipe_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  ex_mult_if.ctrl           mult,
  input  ex_pkg::word_t     alu_result_i,
  input  logic              alu_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);
  import ex_pkg::*;

  logic      units_ready; // Nothing in EX is stalling
  logic      any_en;      // Some unit holds an instruction
  logic      we_lsu_q;
  reg_addr_t waddr_lsu_q;

  ////////////////////
  // Forwarding port
  ////////////////////
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Later assignment wins, CSR over MULT over ALU
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
    if (mult.en) begin
      regfile_alu_wdata_fw_o = mult.result;
    end
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q <= 1'b0;
    end else if (ex_valid_o) begin
      we_lsu_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      we_lsu_q <= 1'b0; // Bubble, flush the slot
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      waddr_lsu_q <= regfile_waddr_i;
    end
  end

  assign regfile_we_wb_o    = we_lsu_q;
  assign regfile_waddr_wb_o = waddr_lsu_q;
  assign regfile_wdata_wb_o = lsu_rdata_i; // Load data arrives in WB

  ////////////////////
  // Handshake
  ////////////////////
  assign units_ready = mult.ready & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult.en | csr_access_i | lsu_en_i;

  // Branches resolve here and never need WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = any_en & units_ready;
  assign mult.ex_ready = ex_ready_o;

  // A valid handoff needs WB and lands in the register on the next edge
  assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> wb_ready_i ##1 (regfile_we_wb_o == $past(regfile_we_i)));

endmodule

// File: source/ex_stage.sv
////////////////////
// Execute stage top
// ALU, multiplier and stage control behind plain ports
////////////////////
module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,  // Jump target
  input  logic              alu_en_i,
  // Multiplier
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  logic              mult_en_i,
  output logic              mult_multicycle_o,
  // CSR
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  // From ID
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,     // Passed on to WB
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  // LSU
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              branch_in_ex_i,
  input  logic              wb_ready_i,
  // Forwarding port
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  // Load/store port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  // To IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  // Stall
  output logic              ex_ready_o,
  output logic              ex_valid_o
);
  import ex_pkg::*;

  word_t alu_result;

  ex_mult_if mult_if ();

  // Multiplier operands straight from ID
  assign mult_if.en   = mult_en_i;
  assign mult_if.op   = mult_operator_i;
  assign mult_if.op_a = mult_operand_a_i;
  assign mult_if.op_b = mult_operand_b_i;
  assign mult_multicycle_o = mult_if.multicycle;

  assign jump_target_o = alu_operand_c_i;

  ////////////////////
  // Units
  ////////////////////
  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .enable_i            (alu_en_i),
    .result_o            (alu_result),
    .comparison_result_o (branch_decision_o)
  );

  ex_mult u_mult (
    .clk  (clk),
    .rst_n(rst_n),
    .mult (mult_if.unit)
  );

  ex_pipe_ctrl u_ctrl (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .mult                  (mult_if.ctrl),
    .alu_result_i          (alu_result),
    .alu_en_i              (alu_en_i),
    .csr_access_i          (csr_access_i),
    .csr_rdata_i           (csr_rdata_i),
    .regfile_alu_we_i      (regfile_alu_we_i),
    .regfile_alu_waddr_i   (regfile_alu_waddr_i),
    .regfile_we_i          (regfile_we_i),
    .regfile_waddr_i       (regfile_waddr_i),
    .lsu_en_i              (lsu_en_i),
    .lsu_rdata_i           (lsu_rdata_i),
    .lsu_ready_ex_i        (lsu_ready_ex_i),
    .branch_in_ex_i        (branch_in_ex_i),
    .wb_ready_i            (wb_ready_i),
    .regfile_alu_we_fw_o   (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw_o),
    .regfile_we_wb_o       (regfile_we_wb_o),
    .regfile_waddr_wb_o    (regfile_waddr_wb_o),
    .regfile_wdata_wb_o    (regfile_wdata_wb_o),
    .ex_ready_o            (ex_ready_o),
    .ex_valid_o            (ex_valid_o)
  );

endmodule

// File: sim/tb_ex_stage.sv
////////////////////
// Execute stage testbench
// Directed tests of ALU, branch, multiplier, stall and write ports
////////////////////
module tb_ex_stage;
  import ex_pkg::*;

  localparam int PERIOD     = 40;
  localparam int SETTLE     = PERIOD / 4; // Sample point after the falling edge
  localparam int N_RAND     = 4;          // Random vectors per ALU op
  localparam int RUN_CYCLES = 4 + 16 * N_RAND + 14 + 5 + 7 + 3 + 3; // Reset plus all tests
  localparam int MARGIN     = 40;

  logic clk, rst_n;
  alu_op_e   alu_operator_i;
  word_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  logic      alu_en_i;
  mult_op_e  mult_operator_i;
  word_t     mult_operand_a_i, mult_operand_b_i;
  logic      mult_en_i, mult_multicycle_o;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      regfile_alu_we_i, regfile_we_i;
  reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic      lsu_en_i, lsu_ready_ex_i, branch_in_ex_i, wb_ready_i;
  word_t     lsu_rdata_i;
  logic      regfile_alu_we_fw_o, regfile_we_wb_o;
  reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  word_t     regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;
  logic      branch_decision_o, ex_ready_o, ex_valid_o;

  logic [31:0] lfsr_q;
  int          err_count, check_count, test_count;

  ex_stage UUT (.*);

  ////////////////////
  // Stimulus and model
  ////////////////////
  // Galois LFSR, one step per bit taken
  function automatic word_t rand_bits(int n);
    word_t w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h80200003 : 32'h0);
      w[i]   = lfsr_q[0];
    end
    return w;
  endfunction

  function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b); // Sign bits differ, negative side is less
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return lt_s;
      ALU_GE:            return !lt_s;
      ALU_LTU, ALU_SLTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a + ~b + 32'd1; // Two's complement
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0); // Fill with sign
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  function automatic word_t mult_model(mult_op_e op, word_t a, word_t b);
    logic signed [63:0] ps;
    logic [63:0]        pu;
    ps = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    pu = {32'h0, a} * {32'h0, b};
    case (op)
      MULT_MULH:  return ps[63:32];
      MULT_MULHU: return pu[63:32];
      default:    return pu[31:0];
    endcase
  endfunction

  task automatic idle_inputs();
    alu_operator_i   = ALU_ADD;
    alu_operand_a_i  = '0;
    alu_operand_b_i  = '0;
    alu_operand_c_i  = '0;
    alu_en_i         = 1'b0;
    mult_operator_i  = MULT_MUL;
    mult_operand_a_i = '0;
    mult_operand_b_i = '0;
    mult_en_i        = 1'b0;
    csr_access_i     = 1'b0;
    csr_rdata_i      = '0;
    {regfile_alu_we_i, regfile_we_i} = 2'b00;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i     = '0;
    lsu_en_i         = 1'b0;
    lsu_rdata_i      = '0;
    lsu_ready_ex_i   = 1'b1;
    branch_in_ex_i   = 1'b0;
    wb_ready_i       = 1'b1;
  endtask

  // Fresh vector on the falling edge
  task automatic start_cycle();
    @(negedge clk);
    idle_inputs();
  endtask

  ////////////////////
  // Checkers
  ////////////////////
  task automatic check_word(string name, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Fail t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic end_test(string name, int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic test_alu_forward();
    alu_op_e op;
    word_t   w;
    int      errs;
    errs = err_count;
    op   = op.first();
    do begin
      for (int i = 0; i < N_RAND; i++) begin
        start_cycle();
        alu_operator_i      = op;
        alu_operand_a_i     = rand_bits(XLEN);
        alu_operand_b_i     = rand_bits(XLEN);
        alu_en_i            = 1'b1;
        w                   = rand_bits(1);
        regfile_alu_we_i    = w[0];
        regfile_alu_waddr_i = reg_addr_t'(rand_bits(REG_ADDR_W));
        #SETTLE;
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
                   alu_model(op, alu_operand_a_i, alu_operand_b_i));
        check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, regfile_alu_we_i);
        check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, regfile_alu_waddr_i);
      end
      op = op.next();
    end while (op != op.first());
    end_test("alu_forward", errs);
  endtask

  task automatic test_branch();
    alu_op_e cmp_ops [6] = '{ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    int      errs;
    errs = err_count;
    foreach (cmp_ops[k]) begin
      for (int j = 0; j < 2; j++) begin
        start_cycle();
        alu_operator_i  = cmp_ops[k];
        alu_operand_a_i = rand_bits(XLEN);
        alu_operand_b_i = (j == 0) ? rand_bits(XLEN) : alu_operand_a_i; // Second pass equal
        alu_operand_c_i = rand_bits(XLEN);
        alu_en_i        = 1'b1;
        #SETTLE;
        check_bit("branch_decision_o", branch_decision_o,
                  cmp_model(cmp_ops[k], alu_operand_a_i, alu_operand_b_i));
        check_word("jump_target_o", jump_target_o, alu_operand_c_i);
      end
    end
    // Branch overrides an LSU stall, then the stall shows again
    for (int j = 0; j < 2; j++) begin
      start_cycle();
      alu_operator_i = ALU_EQ;
      alu_en_i       = 1'b1;
      lsu_ready_ex_i = 1'b0;
      branch_in_ex_i = (j == 0);
      #SETTLE;
      check_bit("ex_ready_o", ex_ready_o, j == 0);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
    end
    end_test("branch", errs);
  endtask

  task automatic test_multiply();
    mult_op_e ops [3] = '{MULT_MUL, MULT_MULH, MULT_MULHU};
    word_t    exp;
    int       errs;
    errs = err_count;
    foreach (ops[k]) begin
      start_cycle();
      mult_en_i        = 1'b1;
      mult_operator_i  = ops[k];
      mult_operand_a_i = rand_bits(XLEN);
      mult_operand_b_i = rand_bits(XLEN);
      exp              = mult_model(ops[k], mult_operand_a_i, mult_operand_b_i);
      #SETTLE;
      if (ops[k] != MULT_MUL) begin
        // High product, stall in the first cycle
        check_bit("ex_ready_o", ex_ready_o, 1'b0);
        check_bit("mult_multicycle_o", mult_multicycle_o, 1'b1);
        check_bit("ex_valid_o", ex_valid_o, 1'b0);
        @(negedge clk);
        #SETTLE;
      end
      check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
      check_bit("ex_ready_o", ex_ready_o, 1'b1);
      check_bit("mult_multicycle_o", mult_multicycle_o, 1'b0);
      check_bit("ex_valid_o", ex_valid_o, 1'b1);
    end
    end_test("multiply", errs);
  endtask

  task automatic test_backpressure();
    word_t exp;
    int    accepts;
    int    errs;
    errs    = err_count;
    accepts = 0;
    start_cycle();
    wb_ready_i       = 1'b0;
    mult_en_i        = 1'b1;
    mult_operator_i  = MULT_MULH;
    mult_operand_a_i = rand_bits(XLEN);
    mult_operand_b_i = rand_bits(XLEN);
    exp              = mult_model(MULT_MULH, mult_operand_a_i, mult_operand_b_i);
    #SETTLE;
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, 1'b0);
    // 3 cycles of WB stall after the product is done, then release
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      wb_ready_i = (i == 3);
      #SETTLE;
      check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
      check_bit("ex_valid_o", ex_valid_o, i == 3);
      check_bit("ex_ready_o", ex_ready_o, i == 3);
      if (ex_valid_o && ex_ready_o) accepts++;
    end
    // Next MULH must start fresh instead of seeing the old result again
    start_cycle();
    mult_en_i        = 1'b1;
    mult_operator_i  = MULT_MULH;
    mult_operand_a_i = rand_bits(XLEN);
    mult_operand_b_i = rand_bits(XLEN);
    exp              = mult_model(MULT_MULH, mult_operand_a_i, mult_operand_b_i);
    #SETTLE;
    if (ex_valid_o) accepts++;
    check_bit("mult_multicycle_o", mult_multicycle_o, 1'b1);
    if (accepts != 1) begin
      err_count++;
      $display("Error t=%0t held MULH result was handed over %0d times, not once",
               $time, accepts);
    end
    @(negedge clk);
    #SETTLE;
    check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp);
    end_test("backpressure", errs);
  endtask

  task automatic test_lsu_port();
    reg_addr_t addr;
    int        errs;
    errs = err_count;
    start_cycle();
    addr            = reg_addr_t'(rand_bits(REG_ADDR_W));
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = addr;
    #SETTLE;
    check_bit("ex_valid_o", ex_valid_o, 1'b1);
    start_cycle();
    regfile_waddr_i = ~addr; // Must not reach the register
    lsu_rdata_i     = rand_bits(XLEN);
    #SETTLE;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
    check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, addr);
    check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, lsu_rdata_i);
    start_cycle(); // Bubble with WB ready
    #SETTLE;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, addr);
    end_test("lsu_port", errs);
  endtask

  task automatic test_priority();
    int errs;
    errs = err_count;
    start_cycle();
    alu_en_i        = 1'b1;
    alu_operand_a_i = rand_bits(XLEN);
    alu_operand_b_i = rand_bits(XLEN);
    csr_access_i    = 1'b1;
    csr_rdata_i     = rand_bits(XLEN);
    #SETTLE;
    check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, csr_rdata_i);
    @(negedge clk);
    alu_en_i         = 1'b0;
    mult_en_i        = 1'b1;
    mult_operand_a_i = rand_bits(XLEN);
    mult_operand_b_i = rand_bits(XLEN);
    #SETTLE;
    check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, csr_rdata_i);
    @(negedge clk);
    csr_access_i = 1'b0;
    alu_en_i     = 1'b1; // MUL wins over the ALU
    #SETTLE;
    check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o,
               mult_model(MULT_MUL, mult_operand_a_i, mult_operand_b_i));
    end_test("priority", errs);
  endtask

  ////////////////////
  // Clock, watchdog, sequence
  ////////////////////
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(PERIOD * (RUN_CYCLES + MARGIN));
    $display("Watchdog expired, tests did not finish within %0d cycles", RUN_CYCLES + MARGIN);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    lfsr_q      = 32'hf3d9;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    rst_n       = 1'b0;
    idle_inputs();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #SETTLE;
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
    check_bit("mult_multicycle_o", mult_multicycle_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, 1'b1); // Multiplier idle and ready
    test_alu_forward();
    test_branch();
    test_multiply();
    test_backpressure();
    test_lsu_port();
    test_priority();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
source/ex_pkg.sv
source/ex_mult_if.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_pipe_ctrl.sv
source/ex_stage.sv
sim/tb_ex_stage.sv

// File: Makefile
# Verilator simulation of the execute stage testbench
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
LOG       ?= sim.log
FLIST     ?= sim.f
BUILD     ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD) -o V$(TOP)
	@$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '>>> FAIL' $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
